// ==== rtl/loaderPkg.sv ====
`default_nettype none

package loaderPkg;

    typedef logic [15:0] memAddr_t;
    typedef logic [7:0] memByte_t;
    typedef logic [1:0] patternIdx_t;
    typedef logic [3:0] patternRow_t;

    typedef enum logic [3:0] {
        idle,
        clearMem,
        settings,
        patterns,
        tilePtrs,
        windowPtrs,
        spriteEntry,
        drain,
        finished
    } loadPhase_t;

    // Graphics region of the pixel processor
    localparam memAddr_t ClearBase = 16'hC800;
    localparam memAddr_t ClearEnd = 16'hFFFF;

    localparam memAddr_t WindowXAddr = 16'hE8A5;
    localparam memAddr_t WindowYAddr = 16'hE8A6;
    localparam memAddr_t SettingsAddr = 16'hE8A7;
    localparam memByte_t SettingsVal = 8'h01;

    localparam memAddr_t TilePtrBase = 16'hE8A8;
    localparam memAddr_t WindowPtrBase = 16'hF0A8;
    localparam memAddr_t SpritePtrBase = 16'hF300;
    localparam memAddr_t PatternBase = 16'hF800;

    localparam int PatternRows = 16;
    localparam int PatternCount = 3;
    localparam int TilePtrEntries = 1024;
    localparam int WindowPtrEntries = 300;
    localparam int WindowBlankEntries = 280;

    localparam int TilePattern = 0;   // Stripes
    localparam int WindowPattern = 1; // Bright
    localparam int PlayerPattern = 2;

    localparam memByte_t SpriteX = 8'h50;
    localparam memByte_t SpriteY = 8'h32;
    localparam memByte_t SpriteConfig = 8'h0C;

    // Bytes written per phase
    localparam int ClearWrites = ClearEnd - ClearBase + 1;
    localparam int SettingsWrites = 3;
    localparam int PatternWrites = PatternRows * PatternCount;
    localparam int TilePtrWrites = 2 * TilePtrEntries;
    localparam int WindowPtrWrites = 2 * WindowPtrEntries;
    localparam int SpriteEntryWrites = 5;

    // Pointer values stored in the tables
    localparam memAddr_t TilePtrValue = memAddr_t'(PatternBase + PatternRows * TilePattern);
    localparam memAddr_t WindowPtrValue = memAddr_t'(PatternBase + PatternRows * WindowPattern);
    localparam memAddr_t PlayerPtrValue = memAddr_t'(PatternBase + PatternRows * PlayerPattern);

endpackage

`default_nettype wire

// ==== rtl/memWriteIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface memWriteIf import loaderPkg::*; ();

    logic valid;
    logic ready;
    memAddr_t addr;
    memByte_t data;
    logic idle;     // Serializer empty, bus quiet

    modport sequencer (
        output valid,
        output addr,
        output data,
        input ready,
        input idle
    );

    modport serializer (
        input valid,
        input addr,
        input data,
        output ready,
        output idle
    );

endinterface

`default_nettype wire

// ==== rtl/spritePatternRom.sv ====
`timescale 1ns/10ps
`default_nettype none

module spritePatternRom import loaderPkg::*; (
    input wire patternIdx_t pattern,
    input wire patternRow_t row,
    output memByte_t rowBits
);

    memByte_t playerRow;

    // Small figure, one byte per row
    always_comb begin
        case (row)
            4'd0: playerRow = 8'h00;
            4'd1: playerRow = 8'h00;
            4'd2: playerRow = 8'h18;
            4'd3: playerRow = 8'h3C;
            4'd4: playerRow = 8'h18;
            4'd5: playerRow = 8'h7E;
            4'd6: playerRow = 8'h3E;
            4'd7: playerRow = 8'h5E;
            4'd8: playerRow = 8'h3E;
            4'd9: playerRow = 8'h5E;
            4'd10: playerRow = 8'h18;
            4'd11: playerRow = 8'h66;
            4'd12: playerRow = 8'h00;
            4'd13: playerRow = 8'h3C;
            4'd14: playerRow = 8'h00;
            default: playerRow = 8'h00;
        endcase
    end

    always_comb begin
        case (pattern)
            2'd0: begin
                // Stripes alternate between two rows
                rowBits = row[0] ? 8'hCC : 8'hF0;
            end
            2'd1: begin
                rowBits = 8'hFF;            // Bright
            end
            2'd2: begin
                rowBits = playerRow;
            end
            default: begin
                rowBits = 8'h00;            // No fourth pattern
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/initSequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module initSequencer import loaderPkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire logic start,
    input wire logic [15:0] sw,
    memWriteIf.sequencer wr,
    output patternIdx_t pattern,
    output patternRow_t row,
    input wire memByte_t rowBits,
    output logic done
);

    loadPhase_t phase;
    loadPhase_t nextPhase;
    memAddr_t count;        // Byte index within the current phase
    memAddr_t lastCount;
    memAddr_t reqAddr;
    memByte_t reqData;
    memByte_t windowX;
    memByte_t windowY;
    memAddr_t windowPtr;
    logic xfer;

    // Pointers go out high byte first
    function automatic memByte_t ptrByte(memAddr_t ptr, logic lowHalf);
        return lowHalf ? ptr[7:0] : ptr[15:8];
    endfunction

    assign xfer = wr.valid && wr.ready;

    assign pattern = patternIdx_t'(count[5:4]);
    assign row = count[3:0];

    // Blank entries first, then the bright pattern
    assign windowPtr = ({1'b0, count[15:1]} >= memAddr_t'(WindowBlankEntries)) ?
        WindowPtrValue : '0;

    always_comb begin
        reqAddr = ClearBase + count;
        reqData = '0;
        lastCount = '0;
        nextPhase = phase;
        case (phase)
            clearMem: begin
                lastCount = memAddr_t'(ClearWrites - 1);
                nextPhase = settings;
            end
            settings: begin
                lastCount = memAddr_t'(SettingsWrites - 1);
                nextPhase = patterns;
                if (count == 16'd0) begin
                    reqAddr = WindowXAddr;
                    reqData = windowX;
                end else if (count == 16'd1) begin
                    reqAddr = WindowYAddr;
                    reqData = windowY;
                end else begin
                    reqAddr = SettingsAddr;
                    reqData = SettingsVal;
                end
            end
            patterns: begin
                reqAddr = PatternBase + count;
                reqData = rowBits;
                lastCount = memAddr_t'(PatternWrites - 1);
                nextPhase = tilePtrs;
            end
            tilePtrs: begin
                reqAddr = TilePtrBase + count;
                reqData = ptrByte(TilePtrValue, count[0]);
                lastCount = memAddr_t'(TilePtrWrites - 1);
                nextPhase = windowPtrs;
            end
            windowPtrs: begin
                reqAddr = WindowPtrBase + count;
                reqData = ptrByte(windowPtr, count[0]);
                lastCount = memAddr_t'(WindowPtrWrites - 1);
                nextPhase = spriteEntry;
            end
            spriteEntry: begin
                reqAddr = SpritePtrBase + count;
                lastCount = memAddr_t'(SpriteEntryWrites - 1);
                nextPhase = drain;
                case (count[2:0])
                    3'd0: reqData = ptrByte(PlayerPtrValue, 1'b0);
                    3'd1: reqData = ptrByte(PlayerPtrValue, 1'b1);
                    3'd2: reqData = SpriteX;
                    3'd3: reqData = SpriteY;
                    default: reqData = SpriteConfig;
                endcase
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= idle;
            count <= '0;
        end else begin
            case (phase)
                idle: begin
                    if (start) begin
                        phase <= clearMem;
                        count <= '0;
                    end
                end
                drain: begin
                    if (wr.idle)
                        phase <= finished;
                end
                finished: begin
                    phase <= finished;      // Held until reset
                end
                default: begin
                    if (xfer) begin
                        if (count == lastCount) begin
                            phase <= nextPhase;
                            count <= '0;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Window offsets sampled once per run
    always_ff @(posedge clk) begin
        if (phase == idle && start) begin
            windowX <= sw[15:8];
            windowY <= sw[7:0];
        end
    end

    assign wr.valid = phase inside {clearMem, settings, patterns, tilePtrs, windowPtrs,
        spriteEntry};
    assign wr.addr = reqAddr;
    assign wr.data = reqData;

    // Serializer idle here means the last wrEn was on the previous cycle
    assign done = (phase == finished) || (phase == drain && wr.idle);

    addrInMap: assert property (@(posedge clk) disable iff (reset)
        wr.valid |-> (wr.addr >= ClearBase && wr.addr <= ClearEnd));

    stallHold: assert property (@(posedge clk) disable iff (reset)
        wr.valid && !wr.ready |=> wr.valid && $stable(wr.addr) && $stable(wr.data));

endmodule

`default_nettype wire

// ==== rtl/byteBusSerializer.sv ====
`timescale 1ns/10ps
`default_nettype none

module byteBusSerializer import loaderPkg::*; (
    input wire logic clk,
    input wire logic reset,
    memWriteIf.serializer wr,
    output memByte_t wrAddr,
    output memByte_t wrData,
    output logic wrEn,
    output logic addrHigh
);

    typedef enum logic [1:0] {emitIdle, emitHigh, emitLow, emitData} emitState_t;

    emitState_t state;
    memAddr_t curAddr;
    memByte_t curData;
    memAddr_t holdAddr;     // Request taken during the low-byte cycle
    memByte_t holdData;
    logic holdValid;
    logic xfer;

    assign wr.ready = (state == emitIdle) || (state == emitLow);
    assign wr.idle = (state == emitIdle);
    assign xfer = wr.valid && wr.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= emitIdle;
            holdValid <= 1'b0;
        end else begin
            case (state)
                emitIdle: if (xfer) state <= emitHigh;
                emitHigh: state <= emitLow;
                emitLow: begin
                    holdValid <= xfer;
                    state <= emitData;
                end
                default: begin
                    holdValid <= 1'b0;
                    state <= holdValid ? emitLow : emitIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == emitIdle && xfer) begin
            curAddr <= wr.addr;
            curData <= wr.data;
        end else if (state == emitData && holdValid) begin
            curAddr <= holdAddr;
            curData <= holdData;
        end
        if (state == emitLow && xfer) begin
            holdAddr <= wr.addr;
            holdData <= wr.data;
        end
    end

    // Data cycle doubles as the high byte of the held request
    assign addrHigh = (state == emitHigh) || (state == emitData && holdValid);
    assign wrEn = (state == emitData);
    assign wrData = curData;

    always_comb begin
        case (state)
            emitHigh: wrAddr = curAddr[15:8];
            emitLow: wrAddr = curAddr[7:0];
            emitData: wrAddr = holdAddr[15:8];
            default: wrAddr = '0;
        endcase
    end

    singleWrite: assert property (@(posedge clk) disable iff (reset)
        wrEn |=> !wrEn);

    lowBeforeWrite: assert property (@(posedge clk) disable iff (reset)
        wrEn |-> $past(state == emitLow));

endmodule

`default_nettype wire

// ==== rtl/vramLoader.sv ====
`timescale 1ns/10ps
`default_nettype none

module vramLoader import loaderPkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire logic start,
    input wire logic [15:0] sw,
    output logic done,
    output memByte_t wrAddr,
    output memByte_t wrData,
    output logic wrEn,
    output logic addrHigh
);

    patternIdx_t pattern;
    patternRow_t row;
    memByte_t rowBits;

    memWriteIf wrLink ();

    initSequencer sequencer (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .sw      (sw),
        .wr      (wrLink.sequencer),
        .pattern (pattern),
        .row     (row),
        .rowBits (rowBits),
        .done    (done)
    );

    spritePatternRom patternRom (
        .pattern (pattern),
        .row     (row),
        .rowBits (rowBits)
    );

    byteBusSerializer serializer (
        .clk      (clk),
        .reset    (reset),
        .wr       (wrLink.serializer),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .wrEn     (wrEn),
        .addrHigh (addrHigh)
    );

endmodule

`default_nettype wire

// ==== tests/clockGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
    parameter int PeriodNs = 100,
    parameter int ResetCycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    // Power-on reset, released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tests/vramLoaderTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module vramLoaderTb import loaderPkg::*; ();

    localparam int ClockPeriod = 100;
    localparam logic [7:0] PrefillByte = 8'hA5;
    localparam int ExpectedWrites = (ClearEnd - ClearBase + 1) + 3 + PatternRows * PatternCount
        + 2 * TilePtrEntries + 2 * WindowPtrEntries + 5;
    localparam int RunCount = 2;
    localparam int WatchdogCycles = RunCount * 3 * 2 * ExpectedWrites + 300;
    // Stripe rows, row 0 in the top byte
    localparam logic [127:0] StripeBits = 128'hF0CC_F0CC_F0CC_F0CC_F0CC_F0CC_F0CC_F0CC;
    // Player figure, row 0 in the top byte
    localparam logic [127:0] PlayerBits = 128'h0000_183C_187E_3E5E_3E5E_1866_003C_0000;

    logic clk;
    logic powerReset;
    logic runReset;
    logic dutReset;
    logic start;
    logic [15:0] sw;
    logic done;
    logic [7:0] wrAddr;
    logic [7:0] wrData;
    logic wrEn;
    logic addrHigh;

    logic [7:0] mem [0:65535];
    logic [7:0] hiByte = '0;
    logic [7:0] loByte = '0;
    logic lowNext = 1'b0;
    logic framed = 1'b0;
    int writeCount = 0;
    int errorCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    logic [31:0] rngState = 32'd79259;

    assign dutReset = powerReset | runReset;

    clockGen #(.PeriodNs(ClockPeriod), .ResetCycles(5)) clockSource (
        .clk   (clk),
        .reset (powerReset)
    );

    vramLoader i_dut (
        .clk      (clk),
        .reset    (dutReset),
        .start    (start),
        .sw       (sw),
        .done     (done),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .wrEn     (wrEn),
        .addrHigh (addrHigh)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] patternRow(int pattern, int row);
        if (pattern == 0)
            return StripeBits[127 - 8 * row -: 8];
        if (pattern == 1)
            return 8'hFF;
        return PlayerBits[127 - 8 * row -: 8];
    endfunction

    // Final video memory content after one complete load
    function automatic logic [7:0] expectedByte(logic [15:0] addr, logic [15:0] swVal);
        int offset;
        logic [15:0] ptr;
        if (addr < ClearBase)
            return PrefillByte;
        if (addr == WindowXAddr)
            return swVal[15:8];
        if (addr == WindowYAddr)
            return swVal[7:0];
        if (addr == SettingsAddr)
            return SettingsVal;
        if (addr >= PatternBase && addr < PatternBase + PatternRows * PatternCount) begin
            offset = addr - PatternBase;
            return patternRow(offset / PatternRows, offset % PatternRows);
        end
        if (addr >= TilePtrBase && addr < TilePtrBase + 2 * TilePtrEntries) begin
            offset = addr - TilePtrBase;
            ptr = 16'(PatternBase + PatternRows * TilePattern);
            return offset[0] ? ptr[7:0] : ptr[15:8];  // High byte first
        end
        if (addr >= WindowPtrBase && addr < WindowPtrBase + 2 * WindowPtrEntries) begin
            offset = addr - WindowPtrBase;
            if (offset / 2 >= WindowBlankEntries)
                ptr = 16'(PatternBase + PatternRows * WindowPattern);
            else
                ptr = '0;
            return offset[0] ? ptr[7:0] : ptr[15:8];
        end
        if (addr >= SpritePtrBase && addr < SpritePtrBase + 5) begin
            offset = addr - SpritePtrBase;
            ptr = 16'(PatternBase + PatternRows * PlayerPattern);
            case (offset)
                0: return ptr[15:8];
                1: return ptr[7:0];
                2: return SpriteX;
                3: return SpriteY;
                default: return SpriteConfig;
            endcase
        end
        return 8'h00;                       // Cleared
    endfunction

    task automatic compareValue(string testName, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %0h, actual %0h", testName, expected, actual);
            errorCount++;
        end
    endtask

    task automatic finishTest(string testName, int errorsBefore);
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("Test %s: passed", testName);
        end else begin
            $display("Test %s: failed with %0d errors", testName, errorCount - errorsBefore);
            testsFailed++;
        end
    endtask

    task automatic nextSwitch(output logic [15:0] value);
        rngState = xorshift32(rngState);
        value = rngState[15:0];
    endtask

    task automatic pulseStart();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic waitDone();
        while (done !== 1'b1)
            @(negedge clk);
    endtask

    task automatic checkRange(string testName, int first, int last, logic [15:0] swVal);
        for (int a = first; a <= last; a++)
            compareValue($sformatf("%s at %h", testName, a[15:0]),
                32'(expectedByte(a[15:0], swVal)), 32'(mem[a]));
    endtask

    // Bus decoder and memory model, sampled mid-cycle
    initial begin
        for (int a = 0; a < 65536; a++)
            mem[a] = PrefillByte;
        forever begin
            @(negedge clk);
            if (dutReset) begin
                lowNext = 1'b0;
                framed = 1'b0;
            end else begin
                if (wrEn) begin
                    if (!framed) begin
                        $display("Write strobe seen without a framed address");
                        errorCount++;
                    end
                    mem[{hiByte, loByte}] = wrData;
                    writeCount++;
                    framed = 1'b0;
                end
                if (addrHigh) begin
                    hiByte = wrAddr;
                    lowNext = 1'b1;
                end else if (lowNext) begin
                    loByte = wrAddr;
                    lowNext = 1'b0;
                    framed = 1'b1;
                end
            end
        end
    end

    initial begin
        #(WatchdogCycles * ClockPeriod);
        $display("Timeout: the loader did not raise done in the time allowed");
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [15:0] swRun1;
        logic [15:0] swRun2;
        logic [15:0] swLate;
        int errorsBefore;
        int countBefore;
        start = 1'b0;
        sw = '0;
        runReset = 1'b0;
        while (powerReset !== 1'b0)
            @(posedge clk);

        errorsBefore = errorCount;
        repeat (20) begin
            @(negedge clk);
            compareValue("quiet before start", 0, 32'({done, wrEn, addrHigh}));
        end
        finishTest("quiet before start", errorsBefore);

        errorsBefore = errorCount;
        nextSwitch(swRun1);
        @(posedge clk);
        sw <= swRun1;
        pulseStart();
        waitDone();
        checkRange("first run", ClearBase, ClearEnd, swRun1);
        finishTest("first run content", errorsBefore);

        errorsBefore = errorCount;
        checkRange("below region", 0, ClearBase - 1, swRun1);
        compareValue("write count", ExpectedWrites, writeCount);
        finishTest("untouched low memory", errorsBefore);

        // Second run, sw moves after it has been captured
        errorsBefore = errorCount;
        @(posedge clk);
        runReset <= 1'b1;
        repeat (5) @(posedge clk);
        runReset <= 1'b0;
        countBefore = writeCount;
        nextSwitch(swRun2);
        nextSwitch(swLate);
        if (swLate == swRun2)
            swLate = ~swRun2;
        @(posedge clk);
        sw <= swRun2;
        pulseStart();
        repeat (300) @(posedge clk);
        sw <= swLate;
        repeat (200) @(posedge clk);
        start <= 1'b1;                      // Ignored while busy
        @(posedge clk);
        start <= 1'b0;
        waitDone();
        checkRange("second run", ClearBase, ClearEnd, swRun2);
        finishTest("captured switches", errorsBefore);

        errorsBefore = errorCount;
        compareValue("writes in second run", ExpectedWrites, writeCount - countBefore);
        countBefore = writeCount;
        pulseStart();
        repeat (50) @(negedge clk);
        compareValue("writes after done", countBefore, writeCount);
        compareValue("done held", 1, 32'(done));
        finishTest("ignored starts", errorsBefore);

        $display("Tests: %0d run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/loaderPkg.sv
rtl/memWriteIf.sv
rtl/spritePatternRom.sv
rtl/initSequencer.sv
rtl/byteBusSerializer.sv
rtl/vramLoader.sv
tests/clockGen.sv
tests/vramLoaderTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= vramLoaderTb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
